//--- source/mips_pkg.sv
package mips_pkg;

    localparam int DATA_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 6;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [31:0]          instr_t;
    typedef logic [5:0]           opcode_t;
    typedef logic [6:0]           func_t;
    typedef logic [3:0]           shamt_t;
    typedef logic [4:0]           reg_addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [19:0]          out_sel_t;

    // opcodes
    localparam opcode_t OPCODE_RTYPE = 6'b000000;
    localparam opcode_t OPCODE_ADDI  = 6'b001000;

    // r-type function codes
    localparam func_t FUNC_ADD = 7'b0100000;
    localparam func_t FUNC_AND = 7'b0100100;
    localparam func_t FUNC_OR  = 7'b0100101;
    localparam func_t FUNC_NOR = 7'b0100111;
    localparam func_t FUNC_SLL = 7'b0000000;
    localparam func_t FUNC_SRL = 7'b0000010;
    localparam func_t FUNC_GCD = 7'b1111000;

    // sparse register addresses, listed by physical index
    localparam reg_addr_t REG_ADDR_TABLE [NUM_REGS] = '{
        5'd17,
        5'd18,
        5'd8,
        5'd23,
        5'd31,
        5'd16
    };

    // returns {valid, index}, all zero when the address is not mapped
    function automatic logic [REG_IDX_W:0] reg_lookup(input reg_addr_t addr);
        logic [REG_IDX_W:0] hit;
        hit = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (addr == REG_ADDR_TABLE[i]) begin
                hit = {1'b1, reg_idx_t'(i)};
            end
        end
        return hit;
    endfunction

endpackage

//--- source/mips_decode.sv
`timescale 1ns/1ns

module mips_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                accept,
    input  mips_pkg::instr_t    instruction,
    input  mips_pkg::out_sel_t  output_reg,
    input  mips_pkg::data_t     rs_val,
    input  mips_pkg::data_t     rt_val,
    output mips_pkg::reg_addr_t rs_addr,
    output mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::reg_addr_t rd_addr,
    output mips_pkg::reg_addr_t out_addr_1,
    output mips_pkg::reg_addr_t out_addr_2,
    output mips_pkg::reg_addr_t out_addr_3,
    output mips_pkg::reg_addr_t out_addr_4,
    output mips_pkg::func_t     func,
    output mips_pkg::shamt_t    shamt,
    output mips_pkg::data_t     imm,
    output logic                is_rtype,
    output logic                is_gcd,
    output logic                instr_bad
);

    import mips_pkg::*;

    instr_t   instr_q;
    out_sel_t sel_q;
    opcode_t  opcode;

    logic [REG_IDX_W:0] rs_hit;
    logic [REG_IDX_W:0] rt_hit;
    logic [REG_IDX_W:0] rd_hit;
    logic               opcode_bad;
    logic               func_bad;
    logic               addr_bad;
    logic               gcd_zero;

    // instruction and selector captured when idle and in_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_q <= '0;
            sel_q   <= '0;
        end else if (accept) begin
            instr_q <= instruction;
            sel_q   <= output_reg;
        end
    end

    // field split
    assign opcode   = instr_q[31:26];
    assign is_rtype = (opcode == OPCODE_RTYPE);
    assign rs_addr  = instr_q[25:21];
    assign rt_addr  = instr_q[20:16];
    // addi writes back into rt
    assign rd_addr  = is_rtype ? instr_q[15:11] : instr_q[20:16];
    assign shamt    = instr_q[10:7];
    assign func     = instr_q[6:0];
    assign imm      = instr_q[15:0];
    assign is_gcd   = is_rtype && (func == FUNC_GCD);

    assign out_addr_1 = sel_q[4:0];
    assign out_addr_2 = sel_q[9:5];
    assign out_addr_3 = sel_q[14:10];
    assign out_addr_4 = sel_q[19:15];

    // failure checks
    always_comb begin
        rs_hit = reg_lookup(rs_addr);
        rt_hit = reg_lookup(rt_addr);
        rd_hit = reg_lookup(rd_addr);

        opcode_bad = (opcode != OPCODE_RTYPE) && (opcode != OPCODE_ADDI);

        case (func)
            FUNC_ADD, FUNC_AND, FUNC_OR, FUNC_NOR,
            FUNC_SLL, FUNC_SRL, FUNC_GCD: func_bad = 1'b0;
            default:                      func_bad = 1'b1;
        endcase

        // rd equals rt for addi, so the same three checks cover both forms
        addr_bad = !rs_hit[REG_IDX_W] || !rt_hit[REG_IDX_W] || !rd_hit[REG_IDX_W];

        gcd_zero = is_gcd && ((rs_val == '0) || (rt_val == '0));

        instr_bad = opcode_bad || addr_bad || (is_rtype && func_bad) || gcd_zero;
    end

endmodule

//--- source/mips_reg_file.sv
`timescale 1ns/1ns

module mips_reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  mips_pkg::reg_addr_t rd_addr,
    input  mips_pkg::reg_addr_t out_addr_1,
    input  mips_pkg::reg_addr_t out_addr_2,
    input  mips_pkg::reg_addr_t out_addr_3,
    input  mips_pkg::reg_addr_t out_addr_4,
    input  logic                we,
    input  mips_pkg::data_t     wdata,
    input  logic                show_out,
    output mips_pkg::data_t     rs_val,
    output mips_pkg::data_t     rt_val,
    output mips_pkg::data_t     out_1,
    output mips_pkg::data_t     out_2,
    output mips_pkg::data_t     out_3,
    output mips_pkg::data_t     out_4
);

    import mips_pkg::*;

    data_t regs [NUM_REGS];

    logic [REG_IDX_W:0] wr_hit;

    // unmapped addresses read as zero
    function automatic data_t read_reg(input reg_addr_t addr);
        logic [REG_IDX_W:0] hit;
        hit = reg_lookup(addr);
        if (hit[REG_IDX_W]) begin
            return regs[hit[REG_IDX_W-1:0]];
        end
        return '0;
    endfunction

    assign wr_hit = reg_lookup(rd_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_hit[REG_IDX_W]) begin
            regs[wr_hit[REG_IDX_W-1:0]] <= wdata;
        end
    end

    // operand reads
    always_comb begin
        rs_val = read_reg(rs_addr);
        rt_val = read_reg(rt_addr);
    end

    // display reads, zero outside the out state
    always_comb begin
        out_1 = show_out ? read_reg(out_addr_1) : '0;
        out_2 = show_out ? read_reg(out_addr_2) : '0;
        out_3 = show_out ? read_reg(out_addr_3) : '0;
        out_4 = show_out ? read_reg(out_addr_4) : '0;
    end

endmodule

//--- source/mips_gcd.sv
`timescale 1ns/1ns

module mips_gcd (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  mips_pkg::data_t op_a,
    input  mips_pkg::data_t op_b,
    output mips_pkg::data_t result,
    output logic            gcd_done
);

    import mips_pkg::*;

    data_t  a_q;
    data_t  b_q;
    shamt_t pow_q;
    logic   busy_q;

    logic   a_gt_b;
    data_t  diff;
    shamt_t tz_a;
    shamt_t tz_b;
    shamt_t tz_diff;
    shamt_t tz_shared;
    logic   terminal;
    data_t  survivor;

    // count of trailing zero bits, only meaningful for nonzero values
    function automatic shamt_t trailing_zeros(input data_t v);
        shamt_t n;
        n = '0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (v[i]) begin
                n = shamt_t'(i);
            end
        end
        return n;
    endfunction

    always_comb begin
        a_gt_b    = a_q > b_q;
        diff      = a_gt_b ? (a_q - b_q) : (b_q - a_q);
        tz_a      = trailing_zeros(a_q);
        tz_b      = trailing_zeros(b_q);
        tz_diff   = trailing_zeros(diff);
        tz_shared = (tz_a < tz_b) ? tz_a : tz_b;
        terminal  = (a_q == data_t'(1)) || (b_q == data_t'(1)) ||
                    (a_q == '0) || (b_q == '0) || (a_q == b_q);
    end

    assign gcd_done = busy_q && terminal;

    // a 1 on either side means the odd part is 1
    always_comb begin
        if ((a_q == data_t'(1)) || (b_q == data_t'(1))) begin
            survivor = data_t'(1);
        end else if (a_q == '0) begin
            survivor = b_q;
        end else begin
            survivor = a_q;
        end
        result = survivor << pow_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
        end else if (gcd_done) begin
            busy_q <= 1'b0;
        end
    end

    // one stein step per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            a_q   <= op_a;
            b_q   <= op_b;
            pow_q <= '0;
        end else if (busy_q && !terminal) begin
            if (!a_q[0] || !b_q[0]) begin
                a_q   <= a_q >> tz_a;
                b_q   <= b_q >> tz_b;
                // shared factor of two only counts once
                pow_q <= pow_q + tz_shared;
            end else if (a_gt_b) begin
                a_q <= diff >> tz_diff;
            end else begin
                b_q <= diff >> tz_diff;
            end
        end
    end

endmodule

//--- source/mips_alu.sv
`timescale 1ns/1ns

module mips_alu (
    input  logic             is_rtype,
    input  mips_pkg::func_t  func,
    input  mips_pkg::shamt_t shamt,
    input  mips_pkg::data_t  rs_val,
    input  mips_pkg::data_t  rt_val,
    input  mips_pkg::data_t  imm,
    input  mips_pkg::data_t  gcd_result,
    output mips_pkg::data_t  result
);

    import mips_pkg::*;

    data_t sum_rr;
    data_t or_rr;
    data_t rtype_res;

    always_comb begin
        sum_rr = rs_val + rt_val;
        or_rr  = rs_val | rt_val;

        case (func)
            FUNC_ADD: rtype_res = sum_rr;
            FUNC_AND: rtype_res = rs_val & rt_val;
            FUNC_OR:  rtype_res = or_rr;
            FUNC_NOR: rtype_res = ~or_rr;
            // shifts act on rt
            FUNC_SLL: rtype_res = rt_val << shamt;
            FUNC_SRL: rtype_res = rt_val >> shamt;
            FUNC_GCD: rtype_res = gcd_result;
            default:  rtype_res = '0;
        endcase

        // addi
        result = is_rtype ? rtype_res : (rs_val + imm);
    end

endmodule

//--- source/mips_ctrl.sv
`timescale 1ns/1ns

module mips_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic instr_bad,
    input  logic is_gcd,
    input  logic gcd_done,
    output logic accept,
    output logic gcd_start,
    output logic reg_we,
    output logic show_out,
    output logic out_valid,
    output logic instruction_fail
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CHECK,
        ST_GCD_RUN,
        ST_FAIL,
        ST_OUT
    } state_t;

    state_t state, state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:    if (in_valid) state_nxt = ST_CHECK;
            ST_CHECK: begin
                if (instr_bad) begin
                    state_nxt = ST_FAIL;
                end else if (is_gcd) begin
                    state_nxt = ST_GCD_RUN;
                end else begin
                    state_nxt = ST_OUT;
                end
            end
            ST_GCD_RUN: if (gcd_done) state_nxt = ST_OUT;
            default:    state_nxt = ST_IDLE;
        endcase
    end

    // strobes
    assign accept           = (state == ST_IDLE) && in_valid;
    assign gcd_start        = (state == ST_CHECK) && !instr_bad && is_gcd;
    assign reg_we           = ((state == ST_CHECK) && !instr_bad && !is_gcd) ||
                              ((state == ST_GCD_RUN) && gcd_done);
    assign show_out         = (state == ST_OUT);
    assign out_valid        = (state == ST_OUT) || (state == ST_FAIL);
    assign instruction_fail = (state == ST_FAIL);

endmodule

//--- source/mips_top.sv
`timescale 1ns/1ns

module mips_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  mips_pkg::instr_t   instruction,
    input  mips_pkg::out_sel_t output_reg,
    output logic               out_valid,
    output logic               instruction_fail,
    output mips_pkg::data_t    out_1,
    output mips_pkg::data_t    out_2,
    output mips_pkg::data_t    out_3,
    output mips_pkg::data_t    out_4
);

    import mips_pkg::*;

    logic      accept;
    logic      gcd_start;
    logic      gcd_done;
    logic      reg_we;
    logic      show_out;
    logic      instr_bad;
    logic      is_gcd;
    logic      is_rtype;

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t rd_addr;
    reg_addr_t out_addr_1;
    reg_addr_t out_addr_2;
    reg_addr_t out_addr_3;
    reg_addr_t out_addr_4;
    func_t     func;
    shamt_t    shamt;
    data_t     imm;
    data_t     rs_val;
    data_t     rt_val;
    data_t     gcd_result;
    data_t     alu_result;

    mips_ctrl u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .instr_bad        (instr_bad),
        .is_gcd           (is_gcd),
        .gcd_done         (gcd_done),
        .accept           (accept),
        .gcd_start        (gcd_start),
        .reg_we           (reg_we),
        .show_out         (show_out),
        .out_valid        (out_valid),
        .instruction_fail (instruction_fail)
    );

    mips_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .accept      (accept),
        .instruction (instruction),
        .output_reg  (output_reg),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rd_addr     (rd_addr),
        .out_addr_1  (out_addr_1),
        .out_addr_2  (out_addr_2),
        .out_addr_3  (out_addr_3),
        .out_addr_4  (out_addr_4),
        .func        (func),
        .shamt       (shamt),
        .imm         (imm),
        .is_rtype    (is_rtype),
        .is_gcd      (is_gcd),
        .instr_bad   (instr_bad)
    );

    mips_reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rd_addr    (rd_addr),
        .out_addr_1 (out_addr_1),
        .out_addr_2 (out_addr_2),
        .out_addr_3 (out_addr_3),
        .out_addr_4 (out_addr_4),
        .we         (reg_we),
        .wdata      (alu_result),
        .show_out   (show_out),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .out_1      (out_1),
        .out_2      (out_2),
        .out_3      (out_3),
        .out_4      (out_4)
    );

    mips_gcd u_gcd (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (gcd_start),
        .op_a     (rs_val),
        .op_b     (rt_val),
        .result   (gcd_result),
        .gcd_done (gcd_done)
    );

    mips_alu u_alu (
        .is_rtype   (is_rtype),
        .func       (func),
        .shamt      (shamt),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .imm        (imm),
        .gcd_result (gcd_result),
        .result     (alu_result)
    );

endmodule

//--- bench/mips_assertions.sv
`timescale 1ns/1ns

module mips_assertions (
    input logic clk,
    input logic rst_n,
    input logic instr_bad,
    input logic out_valid,
    input logic instruction_fail,
    input logic reg_we
);

    int failures = 0;

    // response strobe is a single cycle
    out_valid_single: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid
    ) else begin
        $error("out_valid stayed high for a second cycle");
        failures++;
    end

    // a fail response only follows a failed check
    fail_with_valid: assert property (
        @(posedge clk) disable iff (!rst_n) instruction_fail |-> out_valid && $past(instr_bad)
    ) else begin
        $error("instruction_fail raised without out_valid or without a failed check");
        failures++;
    end

    // a failed instruction never writes
    no_write_on_fail: assert property (
        @(posedge clk) disable iff (!rst_n) reg_we |=> out_valid && !instruction_fail
    ) else begin
        $error("register write not followed by a successful response");
        failures++;
    end

endmodule

bind mips_ctrl mips_assertions u_assertions (
    .clk              (clk),
    .rst_n            (rst_n),
    .instr_bad        (instr_bad),
    .out_valid        (out_valid),
    .instruction_fail (instruction_fail),
    .reg_we           (reg_we)
);

//--- bench/mips_tb.sv
`timescale 1ns/1ns

module mips_tb;

    import mips_pkg::*;

    localparam int          CLK_HALF       = 20;
    localparam int          TIMEOUT_CYCLES = 200;
    localparam logic [15:0] LFSR_SEED      = 16'd52469;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    instr_t   instruction;
    out_sel_t output_reg;
    logic     out_valid;
    logic     instruction_fail;
    data_t    out_1;
    data_t    out_2;
    data_t    out_3;
    data_t    out_4;

    // expected register contents
    data_t     model [6];
    reg_addr_t addr_tab [6] = '{5'd17, 5'd18, 5'd8, 5'd23, 5'd31, 5'd16};

    logic [15:0] lfsr;
    logic [64:0] exp_q [$];
    int          err_count;
    int          check_count;
    int          tests_run;
    int          tests_failed;

    mips_top u_mips_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .instruction      (instruction),
        .output_reg       (output_reg),
        .out_valid        (out_valid),
        .instruction_fail (instruction_fail),
        .out_1            (out_1),
        .out_2            (out_2),
        .out_3            (out_3),
        .out_4            (out_4)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    function automatic int reg_index(input reg_addr_t a);
        case (a)
            5'd17:   return 0;
            5'd18:   return 1;
            5'd8:    return 2;
            5'd23:   return 3;
            5'd31:   return 4;
            5'd16:   return 5;
            default: return -1;
        endcase
    endfunction

    // galois lfsr stepped once per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        lsb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) begin
                lfsr = lfsr ^ 16'hB400;
            end
            r = {r[14:0], lsb};
        end
        return r;
    endfunction

    function automatic reg_addr_t pick_addr();
        return addr_tab[rand_bits(3) % 6];
    endfunction

    function automatic out_sel_t rand_sel();
        return {pick_addr(), pick_addr(), pick_addr(), pick_addr()};
    endfunction

    function automatic data_t euclid_gcd(input data_t a_in, input data_t b_in);
        data_t a;
        data_t b;
        data_t t;
        a = a_in;
        b = b_in;
        while (b != 0) begin
            t = a % b;
            a = b;
            b = t;
        end
        return a;
    endfunction

    // returns {fail, result} from the current model
    function automatic logic [16:0] ref_result(input instr_t ins);
        logic [5:0] op;
        logic [6:0] fn;
        logic [3:0] sh;
        data_t      imm;
        data_t      a;
        data_t      b;
        int         rs_i;
        int         rt_i;
        int         rd_i;
        op   = ins[31:26];
        rs_i = reg_index(ins[25:21]);
        rt_i = reg_index(ins[20:16]);
        rd_i = reg_index(ins[15:11]);
        sh   = ins[10:7];
        fn   = ins[6:0];
        imm  = ins[15:0];
        if (op == 6'b001000) begin
            if (rs_i < 0 || rt_i < 0) return {1'b1, 16'h0};
            return {1'b0, data_t'(model[rs_i] + imm)};
        end
        if (op != 6'b000000 || rs_i < 0 || rt_i < 0 || rd_i < 0) return {1'b1, 16'h0};
        a = model[rs_i];
        b = model[rt_i];
        case (fn)
            7'b0100000: return {1'b0, data_t'(a + b)};
            7'b0100100: return {1'b0, data_t'(a & b)};
            7'b0100101: return {1'b0, data_t'(a | b)};
            7'b0100111: return {1'b0, data_t'(~(a | b))};
            7'b0000000: return {1'b0, data_t'(b << sh)};
            7'b0000010: return {1'b0, data_t'(b >> sh)};
            7'b1111000: begin
                if (a == 0 || b == 0) return {1'b1, 16'h0};
                return {1'b0, euclid_gcd(a, b)};
            end
            default:    return {1'b1, 16'h0};
        endcase
    endfunction

    function automatic logic [63:0] expected_outs(input out_sel_t sel);
        logic [63:0] o;
        int          idx;
        o = '0;
        for (int k = 0; k < 4; k++) begin
            idx = reg_index(sel[5*k +: 5]);
            if (idx >= 0) begin
                o[16*k +: 16] = model[idx];
            end
        end
        return o;
    endfunction

    function automatic instr_t rtype_instr(input reg_addr_t rs, input reg_addr_t rt,
                                           input reg_addr_t rd, input shamt_t sh,
                                           input func_t fn);
        return {OPCODE_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic instr_t itype_instr(input reg_addr_t rs, input reg_addr_t rt,
                                           input data_t imm);
        return {OPCODE_ADDI, rs, rt, imm};
    endfunction

    task automatic check_value(input string name, input data_t got, input data_t exp);
        check_count++;
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            err_count++;
        end
    endtask

    // response checker
    always @(negedge clk) begin : compare
        logic [64:0] e;
        if (rst_n && out_valid) begin
            check_count++;
            assert (exp_q.size() != 0) else begin
                $display("out_valid was raised with no instruction pending");
                err_count++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_value("instruction_fail", data_t'(instruction_fail), data_t'(e[64]));
                check_value("out_1", out_1, e[15:0]);
                check_value("out_2", out_2, e[31:16]);
                check_value("out_3", out_3, e[47:32]);
                check_value("out_4", out_4, e[63:48]);
            end
        end
    end

    // poke sends a second instruction while the DUT is busy
    task automatic exec_instr(input instr_t ins, input out_sel_t sel, input bit poke);
        logic [16:0] r;
        int          dest;
        int          cycles;
        bit          gcd_ok;
        r = ref_result(ins);
        if (!r[16]) begin
            if (ins[31:26] == OPCODE_RTYPE) begin
                dest = reg_index(ins[15:11]);
            end else begin
                dest = reg_index(ins[20:16]);
            end
            model[dest] = r[15:0];
            exp_q.push_back({1'b0, expected_outs(sel)});
        end else begin
            exp_q.push_back({1'b1, 64'd0});
        end
        gcd_ok      = !r[16] && (ins[31:26] == OPCODE_RTYPE) && (ins[6:0] == FUNC_GCD);
        instruction = ins;
        output_reg  = sel;
        in_valid    = 1'b1;
        cycles      = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            in_valid = poke && (cycles == 1);
            if (in_valid) begin
                instruction = itype_instr(addr_tab[0], addr_tab[0], 16'hdead);
            end
        end while (!out_valid && cycles < TIMEOUT_CYCLES);
        if (!out_valid) begin
            $display("timeout, no out_valid within %0d cycles of in_valid", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end else begin
            if (!gcd_ok) begin
                check_count++;
                assert (cycles == 2) else begin
                    $display("out_valid came %0d cycles after acceptance instead of 2", cycles);
                    err_count++;
                end
            end
            @(posedge clk);
            #1;
        end
    endtask

    // or of a register with itself leaves it unchanged
    task automatic read_back_all();
        exec_instr(rtype_instr(addr_tab[0], addr_tab[0], addr_tab[0], 4'd0, FUNC_OR),
                   {addr_tab[3], addr_tab[2], addr_tab[1], addr_tab[0]}, 1'b0);
        exec_instr(rtype_instr(addr_tab[0], addr_tab[0], addr_tab[0], 4'd0, FUNC_OR),
                   {addr_tab[0], 5'd0, addr_tab[5], addr_tab[4]}, 1'b0);
    endtask

    task automatic load_reg(input int idx, input data_t value);
        exec_instr(itype_instr(addr_tab[idx], addr_tab[idx], data_t'(value - model[idx])),
                   rand_sel(), 1'b0);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (err_count == err_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - err_before);
        end
    endtask

    initial begin
        int    e0;
        int    ia;
        int    ib;
        int    total;
        data_t v;
        data_t f;
        func_t fn;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        instruction  = '0;
        output_reg   = '0;
        lfsr         = LFSR_SEED;
        err_count    = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 6; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        e0 = err_count;
        for (int i = 0; i < 6; i++) begin
            v = rand_bits(16);
            if (v == 0) v = 16'h1;
            exec_instr(itype_instr(addr_tab[i], addr_tab[i], v), rand_sel(), 1'b0);
        end
        read_back_all();
        end_test("addi and read-back", e0);

        e0 = err_count;
        for (int i = 0; i < 20; i++) begin
            case (rand_bits(2))
                2'd0:    fn = FUNC_ADD;
                2'd1:    fn = FUNC_AND;
                2'd2:    fn = FUNC_OR;
                default: fn = FUNC_NOR;
            endcase
            exec_instr(rtype_instr(pick_addr(), pick_addr(), pick_addr(), 4'd0, fn),
                       rand_sel(), 1'b0);
        end
        end_test("logic and add", e0);

        e0 = err_count;
        for (int i = 0; i < 12; i++) begin
            fn = rand_bits(1) ? FUNC_SRL : FUNC_SLL;
            exec_instr(rtype_instr(pick_addr(), pick_addr(), pick_addr(),
                                   shamt_t'(rand_bits(4)), fn), rand_sel(), 1'b0);
        end
        end_test("shifts", e0);

        e0 = err_count;
        for (int i = 0; i < 8; i++) begin
            ia = rand_bits(3) % 6;
            ib = (ia + 1 + rand_bits(2)) % 6;
            // shared factor so the result is rarely one
            f = (rand_bits(4) + 16'd1) << rand_bits(2);
            load_reg(ia, data_t'((rand_bits(8) | 16'd1) * f));
            load_reg(ib, data_t'((rand_bits(8) | 16'd1) * f));
            exec_instr(rtype_instr(addr_tab[ia], addr_tab[ib], pick_addr(), 4'd0, FUNC_GCD),
                       rand_sel(), 1'b0);
        end
        end_test("gcd", e0);

        e0 = err_count;
        exec_instr({6'b000100, addr_tab[0], addr_tab[1], 16'h1234}, rand_sel(), 1'b0);
        exec_instr(rtype_instr(5'd3, addr_tab[1], addr_tab[2], 4'd0, FUNC_ADD),
                   rand_sel(), 1'b0);
        exec_instr(rtype_instr(addr_tab[0], addr_tab[1], addr_tab[2], 4'd0, 7'b0001111),
                   rand_sel(), 1'b0);
        load_reg(5, 16'h0);
        exec_instr(rtype_instr(addr_tab[5], addr_tab[0], addr_tab[1], 4'd0, FUNC_GCD),
                   rand_sel(), 1'b0);
        read_back_all();
        end_test("failures", e0);

        e0 = err_count;
        for (int i = 0; i < 6; i++) begin
            exec_instr(rtype_instr(pick_addr(), pick_addr(), pick_addr(), 4'd0, FUNC_ADD),
                       rand_sel(), 1'b1);
        end
        exec_instr({6'b000100, addr_tab[0], addr_tab[1], 16'h1234}, rand_sel(), 1'b1);
        read_back_all();
        end_test("latency and busy input", e0);

        check_count++;
        assert (exp_q.size() == 0) else begin
            $display("%0d expected responses never arrived", exp_q.size());
            err_count++;
        end
        total = err_count + u_mips_top.u_ctrl.u_assertions.failures;
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, check_count, err_count,
                 u_mips_top.u_ctrl.u_assertions.failures);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sim.f
source/mips_pkg.sv
source/mips_decode.sv
source/mips_reg_file.sv
source/mips_gcd.sv
source/mips_alu.sv
source/mips_ctrl.sv
source/mips_top.sv
bench/mips_assertions.sv
bench/mips_tb.sv
